// ==== memAlign_defines.svh ====
`ifndef MEMALIGN_DEFINES_SVH
`define MEMALIGN_DEFINES_SVH

// address and line geometry
`define VADDR_BITS     32
`define PAGE_BITS      12
`define LINE_BYTES     16
`define LINE_OFF_BITS  4
`define REQ_BYTES      8

// tlb entry layout
`define TLB_ENTRIES    8
`define VPN_BITS       20
`define PFN_BITS       3
`define FLAG_BITS      4
`define TLB_FLAG_VALID    0
`define TLB_FLAG_PRESENT  1
`define TLB_FLAG_WRITABLE 2
`define TLB_FLAG_UNCACHED 3

// wishbone config port
`define WB_ADR_BITS    6
`define WB_DAT_BITS    32
`define WB_SEL_BITS    4
// flags sit at bits 7..4 of the pfn word
`define TLB_FLAG_LSB   4

`endif

// ==== memAlignPkg.sv ====
`include "memAlign_defines.svh"

package memAlignPkg;

    // virtual and physical byte addresses
    typedef logic [`VADDR_BITS-1:0] vAddrT;
    typedef logic [`PFN_BITS+`PAGE_BITS-1:0] pAddrT;

    // physical line address, offset bits dropped
    typedef logic [`PFN_BITS+`PAGE_BITS-`LINE_OFF_BITS-1:0] lineAddrT;

    // page numbers
    typedef logic [`VPN_BITS-1:0] vpnT;
    typedef logic [`PFN_BITS-1:0] pfnT;

    // one cache line worth of lanes
    typedef logic [`LINE_BYTES-1:0] byteMaskT;
    typedef logic [`LINE_BYTES*8-1:0] lineDataT;

    // request payload, little endian
    typedef logic [`REQ_BYTES*8-1:0] reqDataT;

    // byte count is 1 << code
    typedef logic [1:0] accSizeT;

    // valid, present, writable, uncached from bit 0 up
    typedef logic [`FLAG_BITS-1:0] tlbFlagsT;

    // wishbone slave states
    typedef enum logic {
        stIdle,
        stAck
    } wbState;

endpackage

// ==== tlbRegs.sv ====
`timescale 1ns/100ps
`include "memAlign_defines.svh"

module tlbRegs (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   wbCyc,
    input  logic                                   wbStb,
    input  logic                                   wbWe,
    input  logic [`WB_ADR_BITS-1:0]                wbAdr,
    input  logic [`WB_DAT_BITS-1:0]                wbDatW,
    input  logic [`WB_SEL_BITS-1:0]                wbSel,
    output logic [`WB_DAT_BITS-1:0]                wbDatR,
    output logic                                   wbAck,
    output logic [`TLB_ENTRIES*`VPN_BITS-1:0]      tlbVpn,
    output logic [`TLB_ENTRIES*`PFN_BITS-1:0]      tlbPfn,
    output logic [`TLB_ENTRIES*`FLAG_BITS-1:0]     tlbFlags
);
    import memAlignPkg::*;

    vpnT      vpnQ   [`TLB_ENTRIES];
    pfnT      pfnQ   [`TLB_ENTRIES];
    tlbFlagsT flagsQ [`TLB_ENTRIES];

    wbState                    state;
    logic                      access;
    logic                      wrEn;
    logic [`WB_ADR_BITS-4:0]   entry;
    logic                      fieldSel;
    logic [`WB_DAT_BITS-1:0]   rdData;

    // word 2i is the vpn, word 2i+1 holds pfn and flags
    assign entry    = wbAdr[`WB_ADR_BITS-1:3];
    assign fieldSel = wbAdr[2];
    assign access   = (state == stIdle) && wbCyc && wbStb;
    assign wrEn     = access && wbWe;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (wbCyc && wbStb) begin
                        state <= stAck;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    assign wbAck = (state == stAck);

    // unused bits read back as zero
    always_comb begin
        rdData = '0;
        if (fieldSel) begin
            rdData[`PFN_BITS-1:0] = pfnQ[entry];
            rdData[`TLB_FLAG_LSB +: `FLAG_BITS] = flagsQ[entry];
        end else begin
            rdData[`VPN_BITS-1:0] = vpnQ[entry];
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wbWe) begin
            wbDatR <= rdData;
        end
    end

    // byte lanes of the vpn word
    always_ff @(posedge clk) begin
        if (wrEn && !fieldSel) begin
            if (wbSel[0]) begin
                vpnQ[entry][7:0] <= wbDatW[7:0];
            end
            if (wbSel[1]) begin
                vpnQ[entry][15:8] <= wbDatW[15:8];
            end
            if (wbSel[2]) begin
                vpnQ[entry][`VPN_BITS-1:16] <= wbDatW[`VPN_BITS-1:16];
            end
        end
        if (wrEn && fieldSel && wbSel[0]) begin
            pfnQ[entry] <= wbDatW[`PFN_BITS-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                flagsQ[i] <= '0;
            end
        end else if (wrEn && fieldSel && wbSel[0]) begin
            flagsQ[entry] <= wbDatW[`TLB_FLAG_LSB +: `FLAG_BITS];
        end
    end

    // flatten for the lookup side
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            tlbVpn[i*`VPN_BITS +: `VPN_BITS]    = vpnQ[i];
            tlbPfn[i*`PFN_BITS +: `PFN_BITS]    = pfnQ[i];
            tlbFlags[i*`FLAG_BITS +: `FLAG_BITS] = flagsQ[i];
        end
    end

endmodule

// ==== tlbLookup.sv ====
`timescale 1ns/100ps
`include "memAlign_defines.svh"

module tlbLookup (
    input  memAlignPkg::vAddrT                    vAddr,
    input  logic                                  write,
    input  logic                                  enable,
    input  logic [`TLB_ENTRIES*`VPN_BITS-1:0]     tlbVpn,
    input  logic [`TLB_ENTRIES*`PFN_BITS-1:0]     tlbPfn,
    input  logic [`TLB_ENTRIES*`FLAG_BITS-1:0]    tlbFlags,
    output memAlignPkg::pfnT                      pfn,
    output logic                                  hit,
    output logic                                  miss,
    output logic                                  prot,
    output logic                                  uncached
);
    import memAlignPkg::*;

    vpnT      vpn;
    tlbFlagsT hitFlags;
    logic     found;

    assign vpn = vAddr[`VADDR_BITS-1:`PAGE_BITS];

    // walk from the top so the lowest matching index is left standing
    always_comb begin
        found    = 1'b0;
        pfn      = '0;
        hitFlags = '0;
        for (int i = `TLB_ENTRIES-1; i >= 0; i--) begin
            if (tlbFlags[i*`FLAG_BITS + `TLB_FLAG_VALID] &&
                (tlbVpn[i*`VPN_BITS +: `VPN_BITS] == vpn)) begin
                found    = 1'b1;
                pfn      = tlbPfn[i*`PFN_BITS +: `PFN_BITS];
                hitFlags = tlbFlags[i*`FLAG_BITS +: `FLAG_BITS];
            end
        end
    end

    assign hit  = enable && found;
    assign miss = enable && !found;

    // absent page, or a store to a read-only page
    assign prot = hit && (!hitFlags[`TLB_FLAG_PRESENT] ||
                          (write && !hitFlags[`TLB_FLAG_WRITABLE]));

    assign uncached = hit && hitFlags[`TLB_FLAG_UNCACHED];

endmodule

// ==== accessSplit.sv ====
`timescale 1ns/100ps
`include "memAlign_defines.svh"

module accessSplit (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  reqValid,
    output logic                                  reqReady,
    input  memAlignPkg::vAddrT                    reqVAddr,
    input  memAlignPkg::accSizeT                  reqSize,
    input  logic                                  reqWrite,
    input  memAlignPkg::reqDataT                  reqData,
    input  logic [`TLB_ENTRIES*`VPN_BITS-1:0]     tlbVpn,
    input  logic [`TLB_ENTRIES*`PFN_BITS-1:0]     tlbPfn,
    input  logic [`TLB_ENTRIES*`FLAG_BITS-1:0]    tlbFlags,
    input  logic                                  outReady,
    output logic                                  outValid,
    output logic                                  out0Valid,
    output memAlignPkg::lineAddrT                 out0Line,
    output memAlignPkg::byteMaskT                 out0Mask,
    output memAlignPkg::lineDataT                 out0Data,
    output logic                                  out1Valid,
    output memAlignPkg::lineAddrT                 out1Line,
    output memAlignPkg::byteMaskT                 out1Mask,
    output memAlignPkg::lineDataT                 out1Data,
    output logic                                  outMiss,
    output logic                                  outProt,
    output logic                                  outUncached
);
    import memAlignPkg::*;

    logic [`LINE_OFF_BITS-1:0]                   offset;
    logic [`LINE_OFF_BITS:0]                     bytes;
    logic [`LINE_OFF_BITS:0]                     endPos;
    logic                                        needSecond;
    vAddrT                                       vAddr1;
    pfnT                                         pfn0;
    pfnT                                         pfn1;
    pAddrT                                       pAddr0;
    pAddrT                                       pAddr1;
    logic                                        hit0, miss0, prot0, unc0;
    logic                                        hit1, miss1, prot1, unc1;
    logic [`REQ_BYTES-1:0]                       span;
    logic [`LINE_BYTES+`REQ_BYTES-1:0]           maskWide;
    logic [(`LINE_BYTES+`REQ_BYTES)*8-1:0]       dataWide;
    logic                                        anyMiss, anyProt, anyUnc;
    logic                                        line0Ok, line1Ok;

    // offset 15 plus 8 bytes still fits in 5 bits
    assign offset     = reqVAddr[`LINE_OFF_BITS-1:0];
    assign bytes      = (`LINE_OFF_BITS+1)'(1) << reqSize;
    assign endPos     = {1'b0, offset} + bytes;
    assign needSecond = (endPos > `LINE_BYTES);
    assign vAddr1     = reqVAddr + `LINE_BYTES;

    tlbLookup lookup0 (
        .vAddr    (reqVAddr),
        .write    (reqWrite),
        .enable   (reqValid),
        .tlbVpn   (tlbVpn),
        .tlbPfn   (tlbPfn),
        .tlbFlags (tlbFlags),
        .pfn      (pfn0),
        .hit      (hit0),
        .miss     (miss0),
        .prot     (prot0),
        .uncached (unc0)
    );

    // second line only looked up when the access spills over
    tlbLookup lookup1 (
        .vAddr    (vAddr1),
        .write    (reqWrite),
        .enable   (reqValid && needSecond),
        .tlbVpn   (tlbVpn),
        .tlbPfn   (tlbPfn),
        .tlbFlags (tlbFlags),
        .pfn      (pfn1),
        .hit      (hit1),
        .miss     (miss1),
        .prot     (prot1),
        .uncached (unc1)
    );

    assign pAddr0 = {pfn0, reqVAddr[`PAGE_BITS-1:0]};
    assign pAddr1 = {pfn1, vAddr1[`PAGE_BITS-1:0]};

    // one run of ones across both lines with the upper part in line 1
    assign span     = `REQ_BYTES'((2*`REQ_BYTES)'(1) << bytes) - `REQ_BYTES'(1);
    assign maskWide = (`LINE_BYTES+`REQ_BYTES)'(span) << offset;

    // data shifted to its lanes with bytes past the line end in line 1
    assign dataWide = {{(`LINE_BYTES*8){1'b0}}, reqData} << {offset, 3'b000};

    assign anyMiss = miss0 | miss1;
    assign anyProt = prot0 | prot1;
    assign anyUnc  = unc0 | unc1;

    // any fault kills both lines
    assign line0Ok = hit0 && !anyMiss && !anyProt;
    assign line1Ok = hit1 && !anyMiss && !anyProt;

    assign reqReady = !outValid || outReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid    <= 1'b0;
            out0Valid   <= 1'b0;
            out0Line    <= '0;
            out0Mask    <= '0;
            out0Data    <= '0;
            out1Valid   <= 1'b0;
            out1Line    <= '0;
            out1Mask    <= '0;
            out1Data    <= '0;
            outMiss     <= 1'b0;
            outProt     <= 1'b0;
            outUncached <= 1'b0;
        end else if (reqReady) begin
            outValid    <= reqValid;
            out0Valid   <= line0Ok;
            out0Line    <= line0Ok ? lineAddrT'(pAddr0 >> `LINE_OFF_BITS) : '0;
            out0Mask    <= line0Ok ? maskWide[`LINE_BYTES-1:0] : '0;
            out0Data    <= line0Ok ? dataWide[`LINE_BYTES*8-1:0] : '0;
            out1Valid   <= line1Ok;
            out1Line    <= line1Ok ? lineAddrT'(pAddr1 >> `LINE_OFF_BITS) : '0;
            out1Mask    <= line1Ok ? byteMaskT'(maskWide[`LINE_BYTES +: `REQ_BYTES]) : '0;
            out1Data    <= line1Ok ? lineDataT'(dataWide[`LINE_BYTES*8 +: `REQ_BYTES*8]) : '0;
            outMiss     <= anyMiss;
            outProt     <= anyProt;
            outUncached <= anyUnc;
        end
    end

endmodule

// ==== memAlignTop.sv ====
`timescale 1ns/100ps
`include "memAlign_defines.svh"

module memAlignTop (
    input  logic                       clk,
    input  logic                       rstN,
    // tlb config port
    input  logic                       wbCyc,
    input  logic                       wbStb,
    input  logic                       wbWe,
    input  logic [`WB_ADR_BITS-1:0]    wbAdr,
    input  logic [`WB_DAT_BITS-1:0]    wbDatW,
    input  logic [`WB_SEL_BITS-1:0]    wbSel,
    output logic [`WB_DAT_BITS-1:0]    wbDatR,
    output logic                       wbAck,
    // request side
    input  logic                       reqValid,
    output logic                       reqReady,
    input  memAlignPkg::vAddrT         reqVAddr,
    input  memAlignPkg::accSizeT       reqSize,
    input  logic                       reqWrite,
    input  memAlignPkg::reqDataT       reqData,
    // result side
    input  logic                       outReady,
    output logic                       outValid,
    output logic                       out0Valid,
    output memAlignPkg::lineAddrT      out0Line,
    output memAlignPkg::byteMaskT      out0Mask,
    output memAlignPkg::lineDataT      out0Data,
    output logic                       out1Valid,
    output memAlignPkg::lineAddrT      out1Line,
    output memAlignPkg::byteMaskT      out1Mask,
    output memAlignPkg::lineDataT      out1Data,
    output logic                       outMiss,
    output logic                       outProt,
    output logic                       outUncached
);

    // flattened tlb contents
    logic [`TLB_ENTRIES*`VPN_BITS-1:0]   tlbVpn;
    logic [`TLB_ENTRIES*`PFN_BITS-1:0]   tlbPfn;
    logic [`TLB_ENTRIES*`FLAG_BITS-1:0]  tlbFlags;

    tlbRegs regs0 (
        .clk      (clk),
        .rstN     (rstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbSel    (wbSel),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .tlbVpn   (tlbVpn),
        .tlbPfn   (tlbPfn),
        .tlbFlags (tlbFlags)
    );

    accessSplit split0 (
        .clk         (clk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .reqVAddr    (reqVAddr),
        .reqSize     (reqSize),
        .reqWrite    (reqWrite),
        .reqData     (reqData),
        .tlbVpn      (tlbVpn),
        .tlbPfn      (tlbPfn),
        .tlbFlags    (tlbFlags),
        .outReady    (outReady),
        .outValid    (outValid),
        .out0Valid   (out0Valid),
        .out0Line    (out0Line),
        .out0Mask    (out0Mask),
        .out0Data    (out0Data),
        .out1Valid   (out1Valid),
        .out1Line    (out1Line),
        .out1Mask    (out1Mask),
        .out1Data    (out1Data),
        .outMiss     (outMiss),
        .outProt     (outProt),
        .outUncached (outUncached)
    );

endmodule

// ==== memAlign_checker.sv ====
`timescale 1ns/100ps

module memAlign_checker (
    input logic                    clk,
    input logic                    rstN,
    input logic                    outValid,
    input logic                    outReady,
    input logic                    out0Valid,
    input memAlignPkg::lineAddrT   out0Line,
    input memAlignPkg::byteMaskT   out0Mask,
    input memAlignPkg::lineDataT   out0Data,
    input logic                    out1Valid,
    input memAlignPkg::lineAddrT   out1Line,
    input memAlignPkg::byteMaskT   out1Mask,
    input memAlignPkg::lineDataT   out1Data,
    input logic                    outMiss,
    input logic                    outProt,
    input logic                    outUncached,
    input logic                    wbAck
);

    // a stalled result must not move
    holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> ($stable(outValid) && $stable(out0Valid) &&
        $stable(out0Line) && $stable(out0Mask) && $stable(out0Data) &&
        $stable(out1Valid) && $stable(out1Line) && $stable(out1Mask) &&
        $stable(out1Data) && $stable(outMiss) && $stable(outProt) &&
        $stable(outUncached)))
        else $error("result changed while stalled");

    secondNeedsFirst: assert property (@(posedge clk) disable iff (!rstN)
        out1Valid |-> out0Valid)
        else $error("line 1 valid without line 0");

    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |=> !wbAck)
        else $error("wishbone ack held for two cycles");

    quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("result valid during reset");

endmodule

// the top level sees both the result port and the config port
bind memAlignTop memAlign_checker chk0 (.*);

// ==== tb_memAlign.sv ====
`timescale 1ns/100ps
`include "memAlign_defines.svh"

module tb_memAlign;
    import memAlignPkg::*;

    typedef struct packed {
        logic     v0;
        lineAddrT l0;
        byteMaskT m0;
        lineDataT d0;
        logic     v1;
        lineAddrT l1;
        byteMaskT m1;
        lineDataT d1;
        logic     miss;
        logic     prot;
        logic     unc;
    } resT;

    logic clk = 1'b0;
    logic rstN;
    logic wbCyc, wbStb, wbWe, wbAck;
    logic [`WB_ADR_BITS-1:0] wbAdr;
    logic [`WB_DAT_BITS-1:0] wbDatW, wbDatR;
    logic [`WB_SEL_BITS-1:0] wbSel;
    logic reqValid, reqReady, reqWrite, outReady, outValid;
    vAddrT reqVAddr;
    accSizeT reqSize;
    reqDataT reqData;
    logic out0Valid, out1Valid, outMiss, outProt, outUncached;
    lineAddrT out0Line, out1Line;
    byteMaskT out0Mask, out1Mask;
    lineDataT out0Data, out1Data;

    // shadow of the tlb contents
    vpnT      shVpn   [`TLB_ENTRIES];
    pfnT      shPfn   [`TLB_ENTRIES];
    tlbFlagsT shFlags [`TLB_ENTRIES];

    resT expQ[$];
    integer seed = 32'h4244;
    integer bpSeed = 32'h4244;
    int errors = 0;
    int checks = 0;
    logic timedOut = 1'b0;
    logic bpMode = 1'b0;
    logic pendingOne = 1'b0;
    vpnT pages [9] = '{20'h10, 20'h11, 20'h20, 20'h21, 20'h30, 20'h31, 20'h40, 20'h50, 20'h60};

    memAlignTop dut0 (.*);

    always #4 clk = ~clk;

    // ready toggles at random only in the stall test
    always @(posedge clk) begin
        #1;
        outReady = bpMode ? $random(bpSeed) : 1'b1;
    end

    function automatic void refLookup(vAddrT a, logic wr, logic en, vpnT tv[`TLB_ENTRIES],
                                      pfnT tp[`TLB_ENTRIES], tlbFlagsT tf[`TLB_ENTRIES],
                                      output logic hit, output pfnT pfn,
                                      output logic prot, output logic unc);
        logic found;
        found = 1'b0;
        hit = 1'b0;
        pfn = '0;
        prot = 1'b0;
        unc = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!found && en && tf[i][0] && tv[i] == a[31:12]) begin
                found = 1'b1;
                hit = 1'b1;
                pfn = tp[i];
                prot = !tf[i][1] || (wr && !tf[i][2]);
                unc = tf[i][3];
            end
        end
    endfunction

    function automatic resT refResult(vAddrT a, accSizeT sz, logic wr, reqDataT d,
                                      vpnT tv[`TLB_ENTRIES], pfnT tp[`TLB_ENTRIES],
                                      tlbFlagsT tf[`TLB_ENTRIES]);
        int off;
        int nb;
        int pos;
        logic need;
        vAddrT a1;
        logic h0, h1, p0, p1, u0, u1, ok0, ok1;
        pfnT f0, f1;
        byteMaskT m0, m1;
        lineDataT d0, d1;
        resT r;
        off = a[3:0];
        nb = 1 << sz;
        need = (off + nb) > 16;
        a1 = a + 16;
        refLookup(a, wr, 1'b1, tv, tp, tf, h0, f0, p0, u0);
        refLookup(a1, wr, need, tv, tp, tf, h1, f1, p1, u1);
        m0 = '0;
        m1 = '0;
        d0 = '0;
        d1 = '0;
        // byte k of the request lands at lane off+k
        // lanes past 15 wrap into line 1
        for (int k = 0; k < 8; k++) begin
            pos = off + k;
            if (pos < 16) begin
                m0[pos] = (k < nb);
                d0[pos*8 +: 8] = d[k*8 +: 8];
            end else begin
                m1[pos-16] = (k < nb);
                d1[(pos-16)*8 +: 8] = d[k*8 +: 8];
            end
        end
        r = '0;
        r.miss = !h0 || (need && !h1);
        r.prot = p0 || p1;
        r.unc = u0 || u1;
        ok0 = !r.miss && !r.prot;
        ok1 = ok0 && need;
        if (ok0) begin
            r.v0 = 1'b1;
            r.l0 = {f0, a[11:4]};
            r.m0 = m0;
            r.d0 = d0;
        end
        if (ok1) begin
            r.v1 = 1'b1;
            r.l1 = {f1, a1[11:4]};
            r.m1 = m1;
            r.d1 = d1;
        end
        return r;
    endfunction

    // compare consumed results and queue expectations at acceptance
    always @(posedge clk) begin
        resT expRes;
        resT gotRes;
        if (rstN) begin
            if (pendingOne) begin
                assert (outValid) else begin
                    $display("error at %0t: no result one cycle after acceptance", $time);
                    errors++;
                end
            end
            if (outValid && outReady) begin
                assert (expQ.size() != 0) else begin
                    $display("a result came out with no request pending at %0t", $time);
                    errors++;
                end
                if (expQ.size() != 0) begin
                    expRes = expQ.pop_front();
                    gotRes = {out0Valid, out0Line, out0Mask, out0Data, out1Valid, out1Line,
                              out1Mask, out1Data, outMiss, outProt, outUncached};
                    checks++;
                    assert (gotRes === expRes) else begin
                        $display("error at %0t: result mismatch got %h expected %h",
                                 $time, gotRes, expRes);
                        errors++;
                    end
                end
            end
            pendingOne = reqValid && reqReady;
            if (pendingOne) begin
                expQ.push_back(refResult(reqVAddr, reqSize, reqWrite, reqData,
                                         shVpn, shPfn, shFlags));
            end
        end
    end

    // called at an edge and returns at an edge
    task automatic wbXfer(int word, logic we, logic [31:0] dat, logic [3:0] sel,
                          output logic [31:0] rd);
        int n;
        rd = '0;
        if (timedOut) return;
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = word << 2;
        wbDatW = dat;
        wbSel = sel;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wbAck && n < 50);
        if (!wbAck) begin
            $display("timeout waiting for the wishbone ack at %0t", $time);
            timedOut = 1'b1;
        end
        checks++;
        assert (n == 2) else begin
            $display("error at %0t: ack came %0d cycles after the strobe", $time, n - 1);
            errors++;
        end
        rd = wbDatR;
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        @(posedge clk);
    endtask

    task automatic loadEntry(int i, vpnT vpn, pfnT pfn, tlbFlagsT fl);
        logic [31:0] junk;
        logic [31:0] rd;
        junk = $random(seed);
        wbXfer(2*i, 1'b1, {junk[31:20], vpn}, 4'hF, rd);
        wbXfer(2*i + 1, 1'b1, {junk[23:0], fl, junk[3], pfn}, 4'hF, rd);
        shVpn[i] = vpn;
        shPfn[i] = pfn;
        shFlags[i] = fl;
    endtask

    task automatic sendReq(vAddrT a, accSizeT sz, logic wr, reqDataT d);
        int n;
        if (timedOut) return;
        #1;
        reqValid = 1'b1;
        reqVAddr = a;
        reqSize = sz;
        reqWrite = wr;
        reqData = d;
        n = 0;
        @(posedge clk);
        while (!reqReady) begin
            n++;
            if (n > 100) begin
                $display("timeout waiting for the request to be accepted at %0t", $time);
                timedOut = 1'b1;
                return;
            end
            @(posedge clk);
        end
    endtask

    task automatic randReq();
        vAddrT a;
        a = {pages[$unsigned($random(seed)) % 9], 12'($random(seed))};
        sendReq(a, accSizeT'($random(seed)), 1'($random(seed)),
                {32'($random(seed)), 32'($random(seed))});
    endtask

    task automatic finishTest(string name, int errBefore);
        int n;
        #1;
        reqValid = 1'b0;
        n = 0;
        while (expQ.size() != 0 && !timedOut) begin
            @(posedge clk);
            n++;
            if (n > 500) begin
                $display("timeout waiting for results to drain at %0t", $time);
                timedOut = 1'b1;
            end
        end
        @(posedge clk);
        $display("test %s finished with %0d errors", name, errors - errBefore);
    endtask

    initial begin
        int e;
        logic [31:0] rd;
        rstN = 1'b0;
        {wbCyc, wbStb, wbWe, wbAdr, wbDatW, wbSel} = '0;
        {reqValid, reqVAddr, reqSize, reqWrite, reqData} = '0;
        outReady = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);

        // 0x11 maps to another frame, 0x21 is not present, 0x30 is uncached
        e = errors;
        loadEntry(0, 20'h10, 3'd1, 4'h7);
        loadEntry(1, 20'h11, 3'd5, 4'h7);
        loadEntry(2, 20'h20, 3'd2, 4'h3);
        loadEntry(3, 20'h21, 3'd3, 4'h1);
        loadEntry(4, 20'h30, 3'd4, 4'hF);
        loadEntry(5, 20'h31, 3'd6, 4'h7);
        loadEntry(6, 20'h40, 3'd7, 4'h7);
        loadEntry(7, 20'h50, 3'd0, 4'h0);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            wbXfer(2*i, 1'b0, 32'h0, 4'h0, rd);
            checks++;
            assert (rd == {12'h0, shVpn[i]}) else begin
                $display("error at %0t: vpn word %0d read %h", $time, i, rd);
                errors++;
            end
            wbXfer(2*i + 1, 1'b0, 32'h0, 4'h0, rd);
            checks++;
            assert (rd == {24'h0, shFlags[i], 1'b0, shPfn[i]}) else begin
                $display("error at %0t: pfn word %0d read %h", $time, i, rd);
                errors++;
            end
        end
        $display("test tlb access finished with %0d errors", errors - e);

        e = errors;
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 16; k += (1 << s)) begin
                sendReq(32'h10100 + k, accSizeT'(s), k[0], 64'h0807060504030201);
            end
        end
        finishTest("aligned", e);

        e = errors;
        for (int s = 1; s < 4; s++) begin
            for (int k = 9; k < 16; k++) begin
                sendReq(32'h10020 + k, accSizeT'(s), 1'b1, 64'h8877665544332211);
                sendReq(32'h10FF0 + k, accSizeT'(s), 1'b0, 64'h0123456789ABCDEF);
            end
        end
        finishTest("crossing", e);

        e = errors;
        sendReq(32'h50010, 2'd2, 1'b0, 64'h1);
        sendReq(32'h20040, 2'd3, 1'b1, 64'h2);
        sendReq(32'h20FFC, 2'd3, 1'b0, 64'h3);
        sendReq(32'h30008, 2'd1, 1'b1, 64'h4);
        finishTest("faults", e);

        e = errors;
        bpMode = 1'b1;
        for (int i = 0; i < 60; i++) begin
            randReq();
        end
        finishTest("back-pressure", e);
        bpMode = 1'b0;

        e = errors;
        for (int i = 0; i < 200; i++) begin
            randReq();
        end
        finishTest("random", e);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
memAlignPkg.sv
tlbRegs.sv
tlbLookup.sv
accessSplit.sv
memAlignTop.sv
memAlign_checker.sv
tb_memAlign.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_memAlign
FLIST  := flist.f

SRCS   := $(wildcard *.sv *.svh)
BIN    := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# the exit status comes from grep
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
